// File: Bender.yml
package:
  name: cpu

export_include_dirs:
  - .

sources:
  - files:
      - cpu_pkg.sv
      - register_file.sv
      - alu.sv
      - instr_mem.sv
      - control_unit.sv
      - cpu_top.sv
  - target: test
    files:
      - tb_cpu.sv

// File: alu.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module alu import cpu_pkg::*; (
  input  alu_op_e                    alu_op,
  input  logic                       operand_b_sel,
  input  logic [`CPU_DATA_WIDTH-1:0] operand_a,
  input  logic [`CPU_DATA_WIDTH-1:0] operand_b_reg,
  input  logic [`CPU_DATA_WIDTH-1:0] imm_data,
  output logic [`CPU_DATA_WIDTH-1:0] result,
  output logic                       zero
);

  logic [`CPU_DATA_WIDTH-1:0] operand_b;
  logic [3:0]                 shamt;

  // Immediate forms replace read port 2
  assign operand_b = operand_b_sel ? imm_data : operand_b_reg;

  // Only the low nibble sets the shift distance
  assign shamt = operand_b[3:0];

  //////////////////////////////////////////////////
  // Function select
  //////////////////////////////////////////////////

  always_comb begin
    case (alu_op)
      ALU_ADD:    result = operand_a + operand_b;
      ALU_SUB:    result = operand_a - operand_b;
      ALU_AND:    result = operand_a & operand_b;
      ALU_OR:     result = operand_a | operand_b;
      ALU_XOR:    result = operand_a ^ operand_b;
      // Logical shifts, zeros fill in
      ALU_SHL:    result = operand_a << shamt;
      ALU_SHR:    result = operand_a >> shamt;
      ALU_PASS_B: result = operand_b;
      default:    result = '0;
    endcase
  end

  // Branch test looks at operand A, not the result
  assign zero = (operand_a == '0);

endmodule

// File: control_unit.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module control_unit import cpu_pkg::*; (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          start,
  input  instr_u                        instr,
  input  logic                          zero,
  input  logic [`CPU_DATA_WIDTH-1:0]    alu_result,
  output logic [`CPU_PC_WIDTH-1:0]      pc,
  output logic [`CPU_REG_SEL_WIDTH-1:0] read_select_1,
  output logic [`CPU_REG_SEL_WIDTH-1:0] read_select_2,
  output logic [`CPU_REG_SEL_WIDTH-1:0] write_select,
  output logic                          write,
  output alu_op_e                       alu_op,
  output logic                          operand_b_sel,
  output logic [`CPU_DATA_WIDTH-1:0]    imm_data,
  output logic                          out_valid,
  output logic [`CPU_DATA_WIDTH-1:0]    out_data,
  output logic                          halted
);

  typedef enum logic [1:0] {S_IDLE, S_FETCH, S_EXECUTE, S_HALTED} state_e;

  state_e  state;
  opcode_e opcode;
  logic    exec;

  assign opcode = instr.r.opcode;
  assign exec   = (state == S_EXECUTE);

  //////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////

  always_comb begin
    // Register view by default
    read_select_1 = instr.r.rs1;
    read_select_2 = instr.r.rs2;
    write_select  = instr.r.rd;
    alu_op        = ALU_ADD;
    operand_b_sel = 1'b0;
    imm_data      = {{(`CPU_DATA_WIDTH-IMM_WIDTH){instr.i.imm[IMM_WIDTH-1]}}, instr.i.imm};
    write         = 1'b0;
    case (opcode)
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL, OP_SHR: begin
        alu_op = alu_op_e'(opcode[2:0]);
        write  = exec;
      end
      OP_LDI: begin
        alu_op        = ALU_PASS_B;
        operand_b_sel = 1'b1;
        write         = exec;
      end
      OP_ADDI: begin
        read_select_1 = instr.i.rd;
        operand_b_sel = 1'b1;
        write         = exec;
      end
      OP_BNZ: begin
        read_select_1 = instr.i.rd;
      end
      OP_OUT: begin
        // rd + 0 carries rd through the ALU
        read_select_1 = instr.i.rd;
        operand_b_sel = 1'b1;
        imm_data      = '0;
      end
      default: begin
      end
    endcase
  end

  //////////////////////////////////////////////////
  // Sequencer and PC
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= S_IDLE;
      pc        <= '0;
      halted    <= 1'b0;
      out_valid <= 1'b0;
      out_data  <= '0;
    end else begin
      out_valid <= 1'b0;
      case (state)
        S_IDLE, S_HALTED: begin
          if (start) begin
            pc     <= '0;
            halted <= 1'b0;
            state  <= S_FETCH;
          end
        end
        S_FETCH: state <= S_EXECUTE;
        S_EXECUTE: begin
          state <= S_FETCH;
          pc    <= pc + 1'b1;
          case (opcode)
            OP_BNZ: begin
              if (!zero) begin
                pc <= instr.i.imm[`CPU_PC_WIDTH-1:0];
              end
            end
            OP_OUT: begin
              out_valid <= 1'b1;
              out_data  <= alu_result;
            end
            OP_HALT: begin
              state  <= S_HALTED;
              halted <= 1'b1;
            end
            default: begin
            end
          endcase
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

// File: cpu_pkg.sv
`include "cpu_settings.svh"

package cpu_pkg;

  // Immediate field takes what opcode and rd leave over
  localparam int IMM_WIDTH = `CPU_INSTR_WIDTH - 4 - `CPU_REG_SEL_WIDTH;

  // Register ops 0..6 line up with the ALU codes below
  typedef enum logic [3:0] {
    OP_ADD  = 4'd0,
    OP_SUB  = 4'd1,
    OP_AND  = 4'd2,
    OP_OR   = 4'd3,
    OP_XOR  = 4'd4,
    OP_SHL  = 4'd5,
    OP_SHR  = 4'd6,
    OP_LDI  = 4'd7,
    OP_ADDI = 4'd8,
    OP_BNZ  = 4'd9,
    OP_OUT  = 4'd10,
    OP_HALT = 4'd11
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD    = 3'd0,
    ALU_SUB    = 3'd1,
    ALU_AND    = 3'd2,
    ALU_OR     = 3'd3,
    ALU_XOR    = 3'd4,
    ALU_SHL    = 3'd5,
    ALU_SHR    = 3'd6,
    ALU_PASS_B = 3'd7
  } alu_op_e;

  typedef struct packed {
    opcode_e                       opcode;
    logic [`CPU_REG_SEL_WIDTH-1:0] rd;
    logic [`CPU_REG_SEL_WIDTH-1:0] rs1;
    logic [`CPU_REG_SEL_WIDTH-1:0] rs2;
  } instr_r_t;

  typedef struct packed {
    opcode_e                       opcode;
    logic [`CPU_REG_SEL_WIDTH-1:0] rd;
    logic [IMM_WIDTH-1:0]          imm;
  } instr_i_t;

  // Same word, register view or immediate view
  typedef union packed {
    instr_r_t r;
    instr_i_t i;
  } instr_u;

endpackage

// File: cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Datapath word size
`define CPU_DATA_WIDTH 16

// Register file shape
`define CPU_REG_COUNT 16
`define CPU_REG_SEL_WIDTH 4

// Instruction word and program store
`define CPU_INSTR_WIDTH 16
`define CPU_IMEM_DEPTH 64

// PC covers the whole instruction memory
`define CPU_PC_WIDTH 6

`endif

// File: cpu_top.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_top import cpu_pkg::*; (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        start,
  input  logic                        load_en,
  input  logic [`CPU_PC_WIDTH-1:0]    load_addr,
  input  logic [`CPU_INSTR_WIDTH-1:0] load_data,
  output logic                        out_valid,
  output logic [`CPU_DATA_WIDTH-1:0]  out_data,
  output logic                        halted
);

  instr_u                        instr;
  alu_op_e                       alu_op;
  logic [`CPU_PC_WIDTH-1:0]      pc;
  logic [`CPU_REG_SEL_WIDTH-1:0] read_select_1;
  logic [`CPU_REG_SEL_WIDTH-1:0] read_select_2;
  logic [`CPU_REG_SEL_WIDTH-1:0] write_select;
  logic                          write;
  logic                          operand_b_sel;
  logic                          zero;
  logic [`CPU_DATA_WIDTH-1:0]    imm_data;
  logic [`CPU_DATA_WIDTH-1:0]    read_data_1;
  logic [`CPU_DATA_WIDTH-1:0]    read_data_2;
  logic [`CPU_DATA_WIDTH-1:0]    alu_result;

  control_unit control_unit_i (
    .clk, .rst_n, .start,
    .instr, .zero, .alu_result, .pc,
    .read_select_1, .read_select_2, .write_select,
    .write, .alu_op, .operand_b_sel, .imm_data,
    .out_valid, .out_data, .halted
  );

  register_file register_file_i (
    .clk, .rst_n,
    .read_select_1, .read_select_2, .write_select, .write,
    .write_data (alu_result),
    .read_data_1, .read_data_2
  );

  // Operand A always from read port 1
  alu alu_i (
    .alu_op, .operand_b_sel,
    .operand_a     (read_data_1),
    .operand_b_reg (read_data_2),
    .imm_data,
    .result        (alu_result),
    .zero
  );

  instr_mem instr_mem_i (
    .clk, .load_en, .load_addr, .load_data, .pc, .instr
  );

endmodule

// File: flist.f
+incdir+.
cpu_pkg.sv
register_file.sv
alu.sv
instr_mem.sv
control_unit.sv
cpu_top.sv
tb_cpu.sv

// File: instr_mem.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module instr_mem (
  input  logic                        clk,
  input  logic                        load_en,
  input  logic [`CPU_PC_WIDTH-1:0]    load_addr,
  input  logic [`CPU_INSTR_WIDTH-1:0] load_data,
  input  logic [`CPU_PC_WIDTH-1:0]    pc,
  output logic [`CPU_INSTR_WIDTH-1:0] instr
);

  logic [`CPU_INSTR_WIDTH-1:0] mem [`CPU_IMEM_DEPTH];

  //////////////////////////////////////////////////
  // Program load port
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (load_en) begin
      mem[load_addr] <= load_data;
    end
  end

  //////////////////////////////////////////////////
  // Fetch port
  //////////////////////////////////////////////////

  // Word at pc shows up one cycle later
  always_ff @(posedge clk) begin
    instr <= mem[pc];
  end

endmodule

// File: register_file.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module register_file (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [`CPU_REG_SEL_WIDTH-1:0] read_select_1,
  input  logic [`CPU_REG_SEL_WIDTH-1:0] read_select_2,
  input  logic [`CPU_REG_SEL_WIDTH-1:0] write_select,
  input  logic                          write,
  input  logic [`CPU_DATA_WIDTH-1:0]    write_data,
  output logic [`CPU_DATA_WIDTH-1:0]    read_data_1,
  output logic [`CPU_DATA_WIDTH-1:0]    read_data_2
);

  logic [`CPU_DATA_WIDTH-1:0] regs [`CPU_REG_COUNT];

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `CPU_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (write) begin
      regs[write_select] <= write_data;
    end
  end

  //////////////////////////////////////////////////
  // Read ports
  //////////////////////////////////////////////////

  // Port 1 follows its own select only
  always_comb begin
    read_data_1 = regs[read_select_1];
  end

  // Port 2 likewise, no coupling to port 1
  always_comb begin
    read_data_2 = regs[read_select_2];
  end

endmodule

// File: tb_cpu.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module tb_cpu import cpu_pkg::*; ();

  localparam int TABLE_ROWS  = 13;
  localparam int RANDOM_ROWS = 20;
  localparam int NUM_TESTS   = TABLE_ROWS + RANDOM_ROWS + 4;
  localparam int CYCLE_LIMIT = NUM_TESTS * 64 * 2 + 200;

  logic                        clk;
  logic                        rst_n;
  logic                        start;
  logic                        load_en;
  logic [`CPU_PC_WIDTH-1:0]    load_addr;
  logic [`CPU_INSTR_WIDTH-1:0] load_data;
  logic                        out_valid;
  logic [`CPU_DATA_WIDTH-1:0]  out_data;
  logic                        halted;

  logic [15:0] prog [$];
  logic [15:0] expected [$];
  logic [15:0] seen [$];
  logic [31:0] rng_state;
  logic [3:0]  rand_op;
  logic [7:0]  rand_a;
  logic [7:0]  rand_b;
  int          cycles;
  int          pass_count;
  int          fail_count;
  int          errors;

  // Row fields: opcode, operand a, operand b (8-bit LDI immediates), expected result
  logic [35:0] alu_table [TABLE_ROWS] = '{
    36'h0_05_03_0008, 36'h0_7f_01_0080, 36'h1_03_05_fffe, 36'h1_80_01_ff7f,
    36'h2_f0_3c_0030, 36'h3_0f_f0_ffff, 36'h4_5a_ff_ffa5, 36'h5_01_08_0100,
    36'h5_81_0c_1000, 36'h6_80_08_00ff, 36'h6_7f_0f_0000, 36'h5_03_13_0018,
    36'h6_ff_1f_0001
  };

  cpu_top cpu_top_i (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, a halt never came", cycles);
      $display("Regression failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Reference model and encoders
  //////////////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [15:0] sext(input logic [7:0] v);
    return {{8{v[7]}}, v};
  endfunction

  function automatic logic [15:0] predict(input logic [3:0] op, input logic [15:0] a,
                                          input logic [15:0] b);
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_SHL:  return a << b[3:0];
      OP_SHR:  return a >> b[3:0];
      default: return 16'h0000;
    endcase
  endfunction

  function automatic logic [15:0] enc_i(input logic [3:0] op, input logic [3:0] rd,
                                        input logic [7:0] imm);
    return {op, rd, imm};
  endfunction

  function automatic logic [15:0] enc_r(input logic [3:0] op, input logic [3:0] rd,
                                        input logic [3:0] rs1, input logic [3:0] rs2);
    return {op, rd, rs1, rs2};
  endfunction

  //////////////////////////////////////////////////
  // Load, run and compare
  //////////////////////////////////////////////////

  task automatic load_program();
    for (int i = 0; i < prog.size(); i++) begin
      load_en   = 1'b1;
      load_addr = 6'(i);
      load_data = prog[i];
      @(posedge clk);
      #1;
    end
    load_en = 1'b0;
  endtask

  task automatic run_test(input string name);
    seen.delete();
    load_program();
    start = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
    if (halted) begin
      $display("test %s: halted still high after start", name);
      errors++;
    end
    while (!halted) begin
      @(posedge clk);
      #1;
      if (out_valid) seen.push_back(out_data);
    end
    if (seen.size() != expected.size()) begin
      $display("test %s: expected %0d outputs, saw %0d", name, expected.size(), seen.size());
      errors++;
    end
    for (int i = 0; i < expected.size() && i < seen.size(); i++) begin
      if (seen[i] !== expected[i]) begin
        $display("FAILED t=%0t out_data[%0d] expected %h actual %h",
                 $time, i, expected[i], seen[i]);
        errors++;
      end
    end
    if (errors == 0) begin
      pass_count++;
      $display("test %s: pass", name);
    end else begin
      fail_count++;
      $display("test %s: fail with %0d errors", name, errors);
    end
    errors = 0;
  endtask

  task automatic build_alu_program(input logic [3:0] op, input logic [7:0] a,
                                   input logic [7:0] b);
    prog = '{enc_i(OP_LDI, 1, a), enc_i(OP_LDI, 2, b), enc_r(op, 3, 1, 2),
             enc_i(OP_OUT, 3, 0), enc_i(OP_HALT, 0, 0)};
  endtask

  initial begin
    rst_n      = 1'b0;
    start      = 1'b0;
    load_en    = 1'b0;
    load_addr  = '0;
    load_data  = '0;
    cycles     = 0;
    pass_count = 0;
    fail_count = 0;
    errors     = 0;
    rng_state  = 32'h1a10_bc0e;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Reset values, then a lone HALT
    if (out_valid !== 1'b0) begin
      $display("FAILED t=%0t out_valid expected 0 actual %b", $time, out_valid);
      errors++;
    end
    if (halted !== 1'b0) begin
      $display("FAILED t=%0t halted expected 0 actual %b", $time, halted);
      errors++;
    end
    if (out_data !== 16'h0000) begin
      $display("FAILED t=%0t out_data expected 0000 actual %h", $time, out_data);
      errors++;
    end
    prog = '{enc_i(OP_HALT, 0, 0)};
    expected.delete();
    run_test("reset_halt_only");

    for (int r = 0; r < TABLE_ROWS; r++) begin
      build_alu_program(alu_table[r][35:32], alu_table[r][31:24], alu_table[r][23:16]);
      expected = '{alu_table[r][15:0]};
      run_test($sformatf("alu_row_%0d", r));
    end

    for (int r = 0; r < RANDOM_ROWS; r++) begin
      rng_state = xorshift(rng_state);
      rand_op   = 4'(rng_state[23:16] % 7);
      rand_a    = rng_state[7:0];
      rand_b    = rng_state[15:8];
      build_alu_program(rand_op, rand_a, rand_b);
      expected = '{predict(rand_op, sext(rand_a), sext(rand_b))};
      run_test($sformatf("random_%0d", r));
    end

    // Distinct value in every register, read back in order
    prog.delete();
    expected.delete();
    for (int i = 0; i < 16; i++) begin
      prog.push_back(enc_i(OP_LDI, 4'(i), {i[3:0], ~i[3:0]}));
      expected.push_back(sext({i[3:0], ~i[3:0]}));
    end
    for (int i = 0; i < 16; i++) prog.push_back(enc_i(OP_OUT, 4'(i), 0));
    prog.push_back(enc_i(OP_HALT, 0, 0));
    run_test("register_independence");

    // Countdown: OUT at 1, ADDI -1, BNZ back to 1
    prog = '{enc_i(OP_LDI, 1, 8'd5), enc_i(OP_OUT, 1, 0), enc_i(OP_ADDI, 1, 8'hff),
             enc_i(OP_BNZ, 1, 8'd1), enc_i(OP_HALT, 0, 0)};
    expected = '{16'd5, 16'd4, 16'd3, 16'd2, 16'd1};
    run_test("addi_bnz_loop");

    repeat (20) begin
      @(posedge clk);
      #1;
      if (!halted) begin
        $display("halted dropped while the core sat halted");
        errors++;
      end
      if (out_valid) begin
        $display("an output appeared while the core sat halted");
        errors++;
      end
    end
    prog = '{enc_i(OP_LDI, 4, 8'h2a), enc_i(OP_LDI, 5, 8'h9c), enc_r(OP_ADD, 6, 4, 5),
             enc_i(OP_OUT, 6, 0), enc_i(OP_OUT, 4, 0), enc_i(OP_HALT, 0, 0)};
    expected = '{16'hffc6, 16'h002a};
    run_test("halt_and_restart");

    $display("tests passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule
